// ==== src/wb_pkg.sv ====
// ---------------------------------------------------------------------------
// Bus-side definitions for the Wishbone slave
// ---------------------------------------------------------------------------

package wb_pkg;

   // Default bus geometry
   localparam int WB_WIDTH = 16;           // Data word width
   localparam int WB_BYTES = WB_WIDTH / 8; // One enable per byte lane

   // Kind of an acknowledge still owed to the master.
   // Reads return late (SRAM latency) and writes return on the next cycle,
   // so the bridge tags every accepted strobe with one of these.
   typedef enum logic {
      ACK_READ  = 1'b0,                    // Ack carries dat_o
      ACK_WRITE = 1'b1                     // Ack only, no data
   } ack_kind_e;

endpackage

// ==== src/sram_pkg.sv ====
// ---------------------------------------------------------------------------
// Memory-side definitions for the SRAM and its read pipeline
// ---------------------------------------------------------------------------

package sram_pkg;

   // Default geometry
   localparam int SRAM_WBITS = 4;          // 16 words
   localparam int SRAM_TICKS = 2;          // Read latency in cycles

   // One stage of a read pipeline.
   // The kind bit follows the write-enable sense: 0 read, 1 write
   typedef struct packed {
      logic valid;                         // Stage holds a cycle
      logic kind;                          // 1 for write
   } rd_slot_t;

endpackage

// ==== src/sram_if.sv ====
`timescale 1ns/1ps

// SRAM port bundle between the bridge and the array

interface sram_if #(
   parameter int WIDTH = 16,
   parameter int BYTES = 2,
   parameter int WBITS = 4
) ();

   logic             ce;     // Cycle enable
   logic             we;     // Write when set with ce
   logic [BYTES-1:0] be;     // Byte-lane enables for writes
   logic [WBITS-1:0] ad;     // Word address
   logic [WIDTH-1:0] wdata;  // Write data
   logic [WIDTH-1:0] rdata;  // Read data, TICKS cycles after ce

   // Bridge side
   modport initiator (
      output ce, we, be, ad, wdata,
      input  rdata
   );

   // Memory side
   modport target (
      input  ce, we, be, ad, wdata,
      output rdata
   );

endinterface

// ==== src/wb_sram_interface.sv ====
`timescale 1ns/1ps

// Pipelined Wishbone slave in front of a synchronous SRAM.
// Each accepted strobe becomes one SRAM cycle in the same clock, and a
// shift line of slots remembers which acknowledges are still owed.

module wb_sram_interface #(
   parameter int WIDTH = 16,
   parameter int BYTES = 2,
   parameter int WBITS = 4,
   parameter int TICKS = 2
) (
   input  logic             clk_i,
   input  logic             rst_i,

   // Wishbone B4 pipelined slave
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [WBITS-1:0] adr_i,
   input  logic [BYTES-1:0] sel_i,
   input  logic [WIDTH-1:0] dat_i,
   output logic             ack_o,
   output logic             stall_o,
   output logic             accept_o,  // Strobe taken on this edge
   output logic [WIDTH-1:0] dat_o,

   sram_if.initiator        sram
);

   sram_pkg::rd_slot_t line_q [TICKS]; // Owed acks with slot 0 newest
   sram_pkg::rd_slot_t head;           // Slot entering the line
   wb_pkg::ack_kind_e  req_kind;       // Kind of the strobe on the bus
   logic               rd_busy;        // A read ack is still owed
   logic               wr_ack;
   logic               rd_ack;

   // ------------------------------------------------------------------------
   // Acceptance and stall
   // ------------------------------------------------------------------------
   assign req_kind = we_i ? wb_pkg::ACK_WRITE : wb_pkg::ACK_READ;

   // Look for reads anywhere in the line
   always_comb begin
      rd_busy = 1'b0;
      for (int i = 0; i < TICKS; i++) begin
         if (line_q[i].valid && (line_q[i].kind == wb_pkg::ACK_READ)) begin
            rd_busy = 1'b1;
         end
      end
   end

   // A write would ack ahead of older reads, so hold it off.
   // Reads never stall; one per cycle keeps up to TICKS in flight.
   assign stall_o  = cyc_i && stb_i && we_i && rd_busy;
   assign accept_o = cyc_i && stb_i && !stall_o && !rst_i; // No SRAM cycle in reset

   // ------------------------------------------------------------------------
   // SRAM cycle issued in the accepting clock
   // ------------------------------------------------------------------------
   assign sram.ce    = accept_o;
   assign sram.we    = accept_o && we_i;     // Same cycle as ce
   assign sram.be    = sel_i;                // Byte enables straight from sel
   assign sram.ad    = adr_i;
   assign sram.wdata = dat_i;

   // ------------------------------------------------------------------------
   // Ack tracking line
   // ------------------------------------------------------------------------
   always_comb begin
      head       = '0;
      head.valid = accept_o;
      head.kind  = req_kind;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || !cyc_i) begin
         // Owed acks dropped when the master gives up the bus
         for (int i = 0; i < TICKS; i++) begin
            line_q[i] <= '0;
         end
      end else begin
         line_q[0] <= head;
         for (int i = 1; i < TICKS; i++) begin
            line_q[i] <= line_q[i-1];              // Age by one cycle
         end
      end
   end

   // Writes ack from the newest slot one cycle after accept
   assign wr_ack = line_q[0].valid && (line_q[0].kind == wb_pkg::ACK_WRITE);

   // Reads ack from the oldest slot in step with rdata
   assign rd_ack = line_q[TICKS-1].valid && (line_q[TICKS-1].kind == wb_pkg::ACK_READ);

   // Never both at once since writes wait for the reads to drain
   assign ack_o = wr_ack || rd_ack;

   // Array drives zero between reads
   assign dat_o = sram.rdata;

endmodule

// ==== src/wb_sram_stream.sv ====
`timescale 1ns/1ps

// Streaming Wishbone port: the master sends strobes without an address,
// the ring counter here supplies one per accepted strobe

module wb_sram_stream #(
   parameter int WIDTH = 16,
   parameter int BYTES = 2,
   parameter int WBITS = 4,
   parameter int START = 0,
   parameter int LAST  = 15,
   parameter int STEP  = 1,
   parameter int TICKS = 2
) (
   input  logic             clk_i,
   input  logic             rst_i,

   // Wishbone B4 pipelined slave, no address
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [BYTES-1:0] sel_i,
   input  logic [WIDTH-1:0] dat_i,
   output logic             ack_o,
   output logic             stall_o,
   output logic [WIDTH-1:0] dat_o,

   output logic             wrapped_o,  // One-cycle pulse after the LAST accept

   sram_if.initiator        sram
);

   logic [WBITS-1:0] adr_q;     // Address of the next strobe
   logic [WBITS-1:0] adr_next;
   logic             at_last;   // Current address is the ring end
   logic             accept;    // Strobe taken by the bridge this cycle
   logic             wrap_q;

   // ------------------------------------------------------------------------
   // Ring address counter
   // ------------------------------------------------------------------------
   assign at_last  = (adr_q == WBITS'(LAST));
   assign adr_next = at_last ? WBITS'(START) : adr_q + WBITS'(STEP); // Back to START after LAST

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q <= WBITS'(START);
      end else if (accept) begin
         adr_q <= adr_next;                 // Step only on acceptance
      end
   end

   // Wrap flag, registered from the accept at LAST
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrap_q <= 1'b0;
      end else begin
         wrap_q <= accept && at_last;
      end
   end

   assign wrapped_o = wrap_q;

   // ------------------------------------------------------------------------
   // Bus to SRAM bridge
   // ------------------------------------------------------------------------
   wb_sram_interface #(
      .WIDTH (WIDTH),
      .BYTES (BYTES),
      .WBITS (WBITS),
      .TICKS (TICKS)
   ) u_bridge (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_q),       // Counter supplies the address
      .sel_i    (sel_i),
      .dat_i    (dat_i),
      .ack_o    (ack_o),
      .stall_o  (stall_o),
      .accept_o (accept),      // Advances the counter
      .dat_o    (dat_o),
      .sram     (sram)
   );

endmodule

// ==== src/sram_array.sv ====
`timescale 1ns/1ps

// Synchronous single-port SRAM with byte-lane writes.
// Read data goes through TICKS output stages, so rdata is valid exactly
// TICKS cycles after the ce that asked for it.

module sram_array #(
   parameter int WIDTH = 16,
   parameter int BYTES = 2,
   parameter int WBITS = 4,
   parameter int TICKS = 2
) (
   input  logic   clk_i,
   sram_if.target mem
);

   localparam int WORDS = 1 << WBITS;

   logic [WIDTH-1:0]   ram_q  [WORDS];   // Storage, no reset
   logic [WIDTH-1:0]   data_q [TICKS];   // Output stages
   sram_pkg::rd_slot_t slot_q [TICKS];   // Marks stages that carry a read
   logic               rd_req;
   logic               rd_out;           // Last stage holds read data

   assign rd_req = mem.ce && !mem.we;

   // ------------------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (mem.ce && mem.we) begin
         for (int b = 0; b < BYTES; b++) begin
            if (mem.be[b]) begin
               ram_q[mem.ad][b*8 +: 8] <= mem.wdata[b*8 +: 8]; // Lane b only
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Read pipeline
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      slot_q[0].valid <= mem.ce;
      slot_q[0].kind  <= mem.we;
      if (rd_req) begin
         data_q[0] <= ram_q[mem.ad];                  // First stage, the array read
      end
      for (int i = 1; i < TICKS; i++) begin
         slot_q[i] <= slot_q[i-1];
         if (slot_q[i-1].valid && !slot_q[i-1].kind) begin
            data_q[i] <= data_q[i-1];                 // Move only live reads
         end
      end
   end

   assign rd_out = slot_q[TICKS-1].valid && !slot_q[TICKS-1].kind;

   // Zero when no read is due out
   assign mem.rdata = rd_out ? data_q[TICKS-1] : '0;

endmodule

// ==== src/sram_stream_top.sv ====
`timescale 1ns/1ps

// Streaming Wishbone port onto an on-chip SRAM

module sram_stream_top #(
   parameter int WIDTH = wb_pkg::WB_WIDTH,
   parameter int BYTES = wb_pkg::WB_BYTES,
   parameter int WBITS = sram_pkg::SRAM_WBITS,
   parameter int START = 0,                  // First ring address
   parameter int LAST  = (1 << WBITS) - 1,   // Final ring address
   parameter int STEP  = 1,
   parameter int TICKS = sram_pkg::SRAM_TICKS
) (
   input  logic             clk_i,
   input  logic             rst_i,

   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [BYTES-1:0] sel_i,
   input  logic [WIDTH-1:0] dat_i,
   output logic             ack_o,
   output logic             stall_o,
   output logic [WIDTH-1:0] dat_o,

   output logic             wrapped_o
);

   // Bridge to memory bundle
   sram_if #(
      .WIDTH (WIDTH),
      .BYTES (BYTES),
      .WBITS (WBITS)
   ) u_sram_bus ();

   // ------------------------------------------------------------------------
   // Address generator and bus bridge
   // ------------------------------------------------------------------------
   wb_sram_stream #(
      .WIDTH (WIDTH),
      .BYTES (BYTES),
      .WBITS (WBITS),
      .START (START),
      .LAST  (LAST),
      .STEP  (STEP),
      .TICKS (TICKS)
   ) u_stream (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .sel_i     (sel_i),
      .dat_i     (dat_i),
      .ack_o     (ack_o),
      .stall_o   (stall_o),
      .dat_o     (dat_o),
      .wrapped_o (wrapped_o),
      .sram      (u_sram_bus)
   );

   // ------------------------------------------------------------------------
   // Memory
   // ------------------------------------------------------------------------
   sram_array #(
      .WIDTH (WIDTH),
      .BYTES (BYTES),
      .WBITS (WBITS),
      .TICKS (TICKS)
   ) u_array (
      .clk_i (clk_i),
      .mem   (u_sram_bus)
   );

endmodule

// ==== include/tb_stream_tasks.svh ====
`ifndef TB_STREAM_TASKS_SVH
`define TB_STREAM_TASKS_SVH

// --------------------------------------------------------------------------
// Reference model indexed by ring position
// --------------------------------------------------------------------------
typedef struct {
   wb_pkg::ack_kind_e kind;
   logic [WIDTH-1:0]  data;                 // Expected dat_o for a read
   bit                known;                // Word fully written since start
   int                cyc;                  // Cycle of the accept
} owed_t;

logic [WIDTH-1:0] model_mem   [RING];
bit               model_known [RING];
int               ring_pos;                 // Counter copy where 0 is START
owed_t            owed_q      [$];          // Acks still owed with the oldest first

// Book one accepted strobe and step the counter copy
task automatic note_accept(input logic we, input logic [BYTES-1:0] sel,
                           input logic [WIDTH-1:0] dat, input int cyc);
   owed_t rec;
   rec.kind  = we ? wb_pkg::ACK_WRITE : wb_pkg::ACK_READ;
   rec.data  = model_mem[ring_pos];
   rec.known = model_known[ring_pos];
   rec.cyc   = cyc;
   owed_q.push_back(rec);
   if (we) begin
      for (int b = 0; b < BYTES; b++) begin
         if (sel[b]) begin
            model_mem[ring_pos][b*8 +: 8] = dat[b*8 +: 8]; // Lane b only
         end
      end
      model_known[ring_pos] = model_known[ring_pos] || (&sel);
   end
   ring_pos = (ring_pos == RING - 1) ? 0 : ring_pos + 1; // Back to START after LAST
endtask

// --------------------------------------------------------------------------
// Bus driver helpers that start and end 1 ns after a rising edge
// --------------------------------------------------------------------------
task automatic issue(input logic we, input logic [BYTES-1:0] sel,
                     input logic [WIDTH-1:0] dat, output int waited);
   bit taken;
   taken  = 1'b0;
   waited = 0;
   cyc_i  = 1'b1;
   stb_i  = 1'b1;
   we_i   = we;
   sel_i  = sel;
   dat_i  = dat;
   while (!taken && waited < WAIT_LIMIT) begin
      @(negedge clk_i);                     // Inputs and stall_o settled
      taken = !stall_o;
      waited++;
   end
   if (!taken) abort_run("strobe was never accepted, stall_o stayed high");
   @(posedge clk_i);                        // Accepting edge
   #1;
endtask

task automatic drain_acks();
   int n;
   n     = 0;
   stb_i = 1'b0;
   while (owed_q.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      n++;
   end
   if (owed_q.size() != 0) abort_run("acknowledges still owed after the wait limit");
endtask

task automatic read_word(output logic [WIDTH-1:0] data);
   int waited;
   bit seen;
   seen = 1'b0;
   issue(1'b0, '1, '0, waited);
   stb_i  = 1'b0;
   waited = 0;
   while (!seen && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      seen = ack_o;
      data = dat_o;
      waited++;
   end
   if (!seen) abort_run("read strobe was never acknowledged");
   @(posedge clk_i);
   #1;
endtask

// Read forward until the counter copy sits at pos
task automatic skip_to(input int pos);
   int waited;
   int n;
   n = 0;
   while (ring_pos != pos && n < RING) begin
      issue(1'b0, '1, '0, waited);
      n++;
   end
   drain_acks();
endtask

task automatic end_bus();
   cyc_i = 1'b0;
   stb_i = 1'b0;
   we_i  = 1'b0;
   @(posedge clk_i);                        // One idle cycle between tests
   #1;
endtask

// --------------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------------
task automatic test_full_ring();
   int waited;
   int ack0;
   bus_reset();
   for (int i = 0; i < RING; i++) begin
      issue(1'b1, '1, WIDTH'($urandom()), waited);
   end
   drain_acks();
   ack0 = ack_count;
   for (int i = 0; i < RING; i++) begin
      issue(1'b0, '1, '0, waited);          // stb stays high between reads
   end
   drain_acks();
   check_int("read ack count", ack_count - ack0, RING);
   end_bus();
endtask

task automatic test_wrap();
   int waited;
   bus_reset();
   for (int i = 0; i < 30; i++) begin
      issue(1'b0, '1, '0, waited);
   end
   drain_acks();
   end_bus();
   check_int("wrapped_o pulses", wrap_at.size(), 2);
   if (wrap_at.size() == 2) begin
      check_int("first wrap accept", wrap_at[0], RING);
      check_int("second wrap accept", wrap_at[1], 2 * RING);
   end
endtask

task automatic test_byte_enable();
   logic [WIDTH-1:0] old_w;
   logic [WIDTH-1:0] new_w;
   logic [WIDTH-1:0] got;
   int               pos;
   int               waited;
   pos   = ring_pos;
   old_w = model_mem[pos];
   new_w = WIDTH'($urandom());
   issue(1'b1, BYTES'(1), new_w, waited);   // Low lane only
   drain_acks();
   skip_to(pos);
   read_word(got);
   check_word("dat_o", got, {old_w[WIDTH-1:8], new_w[7:0]});
   end_bus();
endtask

task automatic test_pipeline();
   int waited;
   int acc0;
   int ack0;
   acc0 = accept_count;
   ack0 = ack_count;
   for (int i = 0; i < 8; i++) begin
      issue(1'b0, '1, '0, waited);
      check_int("edges to accept a read", waited, 1);
   end
   drain_acks();
   check_int("read acks", ack_count - ack0, accept_count - acc0);
   end_bus();
endtask

task automatic test_write_after_reads();
   logic [WIDTH-1:0] new_w;
   logic [WIDTH-1:0] got;
   int               pos;
   int               waited;
   issue(1'b0, '1, '0, waited);
   issue(1'b0, '1, '0, waited);
   pos   = ring_pos;
   new_w = WIDTH'($urandom());
   issue(1'b1, '1, new_w, waited);          // Reads still in flight here
   check_true(waited > 1, "stall_o did not hold off a write behind reads");
   drain_acks();
   skip_to(pos);
   read_word(got);
   check_word("dat_o", got, new_w);
   end_bus();
endtask

task automatic test_reset_mid_stream();
   logic [WIDTH-1:0] got;
   int               waited;
   for (int i = 0; i < 5; i++) begin
      issue(1'b0, '1, '0, waited);
   end
   bus_reset();                             // Owed acks dropped
   read_word(got);
   check_word("dat_o", got, model_mem[0]);
   end_bus();
endtask

`endif

// ==== dv/tb_sram_stream.sv ====
`timescale 1ns/1ps

module tb_sram_stream;

   localparam int WIDTH      = 16;
   localparam int BYTES      = 2;
   localparam int WBITS      = 4;
   localparam int START      = 2;
   localparam int LAST       = 13;
   localparam int STEP       = 1;
   localparam int TICKS      = 2;
   localparam int RING       = (LAST - START) / STEP + 1; // 12 words
   localparam int WAIT_LIMIT = 50;                        // Edges per wait

   logic             clk_i;
   logic             rst_i;
   logic             cyc_i;
   logic             stb_i;
   logic             we_i;
   logic [BYTES-1:0] sel_i;
   logic [WIDTH-1:0] dat_i;
   logic             ack_o;
   logic             stall_o;
   logic [WIDTH-1:0] dat_o;
   logic             wrapped_o;

   int          errors;
   int          err0;
   int          tests_run;
   int          tests_failed;
   int          cycle_cnt;
   int          accept_count;   // Since the last reset
   int          ack_count;
   int          wrap_at [$];    // Accept numbers followed by a wrap pulse
   bit          wrap_due;

   sram_stream_top #(
      .WIDTH (WIDTH),
      .BYTES (BYTES),
      .WBITS (WBITS),
      .START (START),
      .LAST  (LAST),
      .STEP  (STEP),
      .TICKS (TICKS)
   ) u_dut (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .sel_i     (sel_i),
      .dat_i     (dat_i),
      .ack_o     (ack_o),
      .stall_o   (stall_o),
      .dat_o     (dat_o),
      .wrapped_o (wrapped_o)
   );

   `include "tb_stream_tasks.svh"

   always #4 clk_i = ~clk_i;                // 8 ns period

   // ------------------------------------------------------------------------
   // Checks and reporting
   // ------------------------------------------------------------------------
   task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_int(input string name, input int got, input int exp);
      assert (got == exp) else begin
         $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond) else begin
         $display("ERROR at %0t: %s", $time, what);
         errors++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("TIMEOUT at %0t: %s", $time, why);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == err0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
      end
      err0 = errors;
   endtask

   task automatic bus_reset();
      rst_i = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      repeat (2) @(posedge clk_i);
      #1 rst_i = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Ack monitor sampling at the falling edge where everything is settled
   // ------------------------------------------------------------------------
   always @(negedge clk_i) begin
      owed_t rec;
      int    reads_left;
      cycle_cnt++;
      reads_left = 0;
      if (rst_i) begin
         owed_q.delete();
         wrap_at.delete();
         ring_pos     = 0;
         accept_count = 0;
         wrap_due     = 1'b0;
      end else begin
         check_int("wrapped_o", int'(wrapped_o), int'(wrap_due));
         if (wrapped_o) wrap_at.push_back(accept_count);
         wrap_due = 1'b0;
         if (cyc_i && ack_o) begin          // Ack taken on the next edge
            ack_count++;
            if (owed_q.size() == 0) begin
               check_true(1'b0, "ack_o raised with no strobe owed");
            end else begin
               rec = owed_q.pop_front();
               check_int("ack latency", cycle_cnt - rec.cyc,
                         (rec.kind == wb_pkg::ACK_READ) ? TICKS : 1);
               if (rec.kind == wb_pkg::ACK_READ && rec.known) begin
                  check_word("dat_o", dat_o, rec.data);
               end
            end
         end
         if (cyc_i && stb_i && !stall_o) begin // Accepted on the next edge
            if (we_i) begin
               foreach (owed_q[i]) begin
                  if (owed_q[i].kind == wb_pkg::ACK_READ) reads_left++;
               end
               check_int("reads owed at write accept", reads_left, 0);
            end
            wrap_due = (ring_pos == RING - 1);
            accept_count++;
            note_accept(we_i, sel_i, dat_i, cycle_cnt);
         end
         if (!cyc_i) owed_q.delete();       // Bridge drops owed acks
      end
   end

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      cyc_i        = 1'b0;
      stb_i        = 1'b0;
      we_i         = 1'b0;
      sel_i        = '0;
      dat_i        = '0;
      errors       = 0;
      err0         = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      accept_count = 0;
      ack_count    = 0;
      wrap_due     = 1'b0;
      ring_pos     = 0;
      void'($urandom(32'he58e));

      test_full_ring();
      finish_test("full ring write then streaming read");
      test_wrap();
      finish_test("ring wrap pulses");
      test_byte_enable();
      finish_test("byte enables");
      test_pipeline();
      finish_test("read pipelining and order");
      test_write_after_reads();
      finish_test("write after reads");
      test_reset_mid_stream();
      finish_test("reset mid-stream");

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+include
src/wb_pkg.sv
src/sram_pkg.sv
src/sram_if.sv
src/wb_sram_interface.sv
src/wb_sram_stream.sv
src/sram_array.sv
src/sram_stream_top.sv
dv/tb_sram_stream.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_sram_stream
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES   := $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
